//--- aes_hwpe.f
logic/aes_package.sv
logic/hwpe_ctrl_package.sv
logic/aes_fsm.sv
logic/aes_stream_source.sv
logic/aes_stream_sink.sv
logic/aes_whitening_engine.sv
logic/aes_hwpe_top.sv
tests/aes_hwpe_properties.sv
tests/aes_hwpe_checker.sv
tests/aes_hwpe_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module aes_hwpe_tb -f aes_hwpe.f -o aes_hwpe_sim

# Let failing assertions be counted instead of stopping the run
./obj_dir/aes_hwpe_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tests/aes_hwpe_golden.txt
# src_base dst_base key(word3..word0) plaintext(word7..word0) ciphertext(word7..word0)
# all hex; word i of a wide field sits in bits 32i+31:32i
00001000 00002000 00000000000000000000000000000000 8888888877777777666666665555555544444444333333332222222211111111 8888888877777777666666665555555544444444333333332222222211111111
00003000 00004000 ffffffffffffffffffffffffffffffff 55aa55aaffffffff0badc0decafef00ddeadbeef89abcdef1234567800000000 aa55aa5500000000f4523f2135010ff22152411076543210edcba987ffffffff
00005000 00006000 ff00000000ff00000000ff00000000ff 0d0e0f00090a0b0c0506070801020304d0e0f00090a0b0c05060708010203040 f20e0f0009f50b0c0506f808010203fb2fe0f000905fb0c050608f80102030bf
80000000 80000100 00000008000000040000000200000001 0000000700000006000000050000000400000003000000020000000100000000 0000000f0000000200000007000000050000000b000000060000000300000001
00000000 00000040 0123456789abcdeffedcba9876543210 0000000000000000000000000000000000000000000000000000000000000000 0123456789abcdeffedcba98765432100123456789abcdeffedcba9876543210

//--- tests/aes_hwpe_tb.sv
`timescale 1ns/100ps
`default_nettype none

module aes_hwpe_tb;

  logic                     clk;
  logic                     reset_n;
  logic                     start;
  hwpe_ctrl_package::addr_t src_base;
  hwpe_ctrl_package::addr_t dst_base;
  aes_package::key_t        key;
  logic                     done;
  logic                     rd_req;
  hwpe_ctrl_package::addr_t rd_addr;
  logic                     rd_ack;
  aes_package::word_t       rd_data;
  logic                     wr_req;
  hwpe_ctrl_package::addr_t wr_addr;
  aes_package::word_t       wr_data;
  logic                     wr_ack;

  // Tests from the golden file
  hwpe_ctrl_package::addr_t src_q[$];
  hwpe_ctrl_package::addr_t dst_q[$];
  aes_package::key_t        key_q[$];
  logic [aes_package::WORDS_PER_BLOCK*aes_package::WORD_BITS-1:0] plain_q[$];
  logic [aes_package::WORDS_PER_BLOCK*aes_package::WORD_BITS-1:0] cipher_q[$];
  logic [aes_package::WORDS_PER_BLOCK*aes_package::WORD_BITS-1:0] exp_block;
  int                       test_idx;

  aes_package::word_t       rd_mem [hwpe_ctrl_package::addr_t];
  logic                     rd_seen;
  logic [31:0]              lfsr_state;
  int                       wr_wait;
  int                       cycles;
  int                       limit;
  int                       chk_errors;
  int                       chk_jobs;

  aes_hwpe_top aes_hwpe_top_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .start_i    (start),
    .src_base_i (src_base),
    .dst_base_i (dst_base),
    .key_i      (key),
    .done_o     (done),
    .rd_req_o   (rd_req),
    .rd_addr_o  (rd_addr),
    .rd_ack_i   (rd_ack),
    .rd_data_i  (rd_data),
    .wr_req_o   (wr_req),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .wr_ack_i   (wr_ack)
  );

  aes_hwpe_checker aes_hwpe_checker_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_i     (start),
    .done_i      (done),
    .rd_req_i    (rd_req),
    .rd_ack_i    (rd_ack),
    .rd_addr_i   (rd_addr),
    .wr_req_i    (wr_req),
    .wr_ack_i    (wr_ack),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .src_base_i  (src_base),
    .dst_base_i  (dst_base),
    .exp_block_i (exp_block),
    .test_idx_i  (test_idx),
    .errors_o    (chk_errors),
    .jobs_o      (chk_jobs)
  );

  bind aes_hwpe_top aes_hwpe_properties aes_hwpe_properties_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .rd_req_i  (rd_req_o),
    .rd_addr_i (rd_addr_o),
    .rd_ack_i  (rd_ack_i),
    .wr_req_i  (wr_req_o),
    .wr_addr_i (wr_addr_o),
    .wr_data_i (wr_data_o),
    .wr_ack_i  (wr_ack_i),
    .done_i    (done_o)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two LFSR bits give an ack delay of 0 to 3 cycles
  function automatic int random_delay();
    logic [1:0] bits;
    lfsr_state = lfsr_next(lfsr_state);
    bits[0]    = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    bits[1]    = lfsr_state[0];
    return int'(bits);
  endfunction

  // Unloaded addresses read back a pattern of the full address
  function automatic aes_package::word_t mem_word(input hwpe_ctrl_package::addr_t addr);
    if (rd_mem.exists(addr)) begin
      return rd_mem[addr];
    end
    return ~addr ^ 32'h3c3c_3c3c;
  endfunction

  task automatic read_golden();
    int                       fd;
    int                       count;
    string                    line;
    hwpe_ctrl_package::addr_t s;
    hwpe_ctrl_package::addr_t d;
    aes_package::key_t        k;
    logic [aes_package::WORDS_PER_BLOCK*aes_package::WORD_BITS-1:0] p;
    logic [aes_package::WORDS_PER_BLOCK*aes_package::WORD_BITS-1:0] c;
    fd = $fopen("tests/aes_hwpe_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/aes_hwpe_golden.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          count = $sscanf(line, "%h %h %h %h %h", s, d, k, p, c);
          if (count == 5) begin
            src_q.push_back(s);
            dst_q.push_back(d);
            key_q.push_back(k);
            plain_q.push_back(p);
            cipher_q.push_back(c);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_job(input int t);
    for (int w = 0; w < aes_package::WORDS_PER_BLOCK; w++) begin
      rd_mem[src_q[t] + hwpe_ctrl_package::addr_t'(w * hwpe_ctrl_package::WORD_BYTES)] =
        plain_q[t][w*aes_package::WORD_BITS +: aes_package::WORD_BITS];
    end
    @(posedge clk);
    #1;
    src_base  = src_q[t];
    dst_base  = dst_q[t];
    key       = key_q[t];
    exp_block = cipher_q[t];
    test_idx  = t;
    start     = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    // Watchdog bounds this wait
    while (!done) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Read memory follows each req edge one cycle later
  always @(posedge clk) begin : read_port
    #1;
    if (rd_req != rd_ack) begin
      if (!rd_seen) begin
        rd_seen = 1'b1;
      end else if (rd_req) begin
        rd_data = mem_word(rd_addr);
        rd_ack  = 1'b1;
        rd_seen = 1'b0;
      end else begin
        rd_ack  = 1'b0;
        rd_data = '0;
        rd_seen = 1'b0;
      end
    end
  end

  always @(posedge clk) begin : write_port
    #1;
    if (wr_req && !wr_ack) begin
      if (wr_wait == 0) begin
        wr_ack = 1'b1;
      end else begin
        wr_wait = wr_wait - 1;
      end
    end else if (!wr_req && wr_ack) begin
      wr_ack  = 1'b0;
      wr_wait = random_delay();
    end
  end

  always @(posedge clk) begin : watchdog
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout: run exceeded %0d cycles", limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin : main
    int n;
    int prop_fails;
    clk        = 1'b0;
    reset_n    = 1'b0;
    start      = 1'b0;
    src_base   = '0;
    dst_base   = '0;
    key        = '0;
    rd_ack     = 1'b0;
    rd_data    = '0;
    rd_seen    = 1'b0;
    wr_ack     = 1'b0;
    exp_block  = '0;
    test_idx   = 0;
    cycles     = 0;
    lfsr_state = 32'hce3e_b95b;
    read_golden();
    n       = src_q.size();
    limit   = n * aes_package::WORDS_PER_BLOCK * 20 + 100;
    wr_wait = random_delay();
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;
    // A few idle cycles so a stray req or done would show
    repeat (3) @(posedge clk);
    #1;
    if (n == 0) begin
      $display("golden file missing or holds no tests");
    end
    for (int t = 0; t < n; t++) begin
      run_job(t);
    end
    repeat (2) @(posedge clk);
    prop_fails = aes_hwpe_top_i.aes_hwpe_properties_i.failures;
    $display("summary: %0d tests, %0d jobs done, %0d check errors, %0d assertion failures",
             n, chk_jobs, chk_errors, prop_fails);
    if (n > 0 && chk_jobs == n && chk_errors == 0 && prop_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/aes_hwpe_checker.sv
`timescale 1ns/100ps
`default_nettype none

module aes_hwpe_checker (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       start_i,
  input  logic                       done_i,
  input  logic                       rd_req_i,
  input  logic                       rd_ack_i,
  input  hwpe_ctrl_package::addr_t   rd_addr_i,
  input  logic                       wr_req_i,
  input  logic                       wr_ack_i,
  input  hwpe_ctrl_package::addr_t   wr_addr_i,
  input  aes_package::word_t         wr_data_i,
  // Expected values of the running test
  input  hwpe_ctrl_package::addr_t   src_base_i,
  input  hwpe_ctrl_package::addr_t   dst_base_i,
  input  logic [aes_package::WORDS_PER_BLOCK*aes_package::WORD_BITS-1:0] exp_block_i,
  input  int                         test_idx_i,
  output int                         errors_o,
  output int                         jobs_o
);

  logic busy;
  logic rd_ack_q;
  logic wr_ack_q;
  int   rd_cnt;
  int   wr_cnt;
  int   test_errors;

  task automatic log_error(input string msg);
    $display("error %0t: test %0d %s", $time, test_idx_i, msg);
    errors_o++;
    test_errors++;
  endtask

  // Sampled mid-cycle, away from DUT updates and testbench drives
  always @(negedge clk) begin : watch
    hwpe_ctrl_package::addr_t exp_addr;
    aes_package::word_t       exp_word;
    if (!reset_n) begin
      busy        = 1'b0;
      rd_ack_q    = 1'b0;
      wr_ack_q    = 1'b0;
      rd_cnt      = 0;
      wr_cnt      = 0;
      test_errors = 0;
      errors_o    = 0;
      jobs_o      = 0;
    end else begin
      if (!busy && (rd_req_i || wr_req_i || done_i)) begin
        log_error("request or done raised with no job running");
      end
      if (start_i) begin
        busy = 1'b1;
      end
      // Read address order, checked at the rise of ack
      if (rd_ack_i && !rd_ack_q) begin
        exp_addr = src_base_i +
                   hwpe_ctrl_package::addr_t'(rd_cnt * hwpe_ctrl_package::WORD_BYTES);
        if (rd_addr_i !== exp_addr) begin
          log_error($sformatf("read %0d address %h, expected %h", rd_cnt, rd_addr_i, exp_addr));
        end
        rd_cnt++;
      end
      if (wr_ack_i && !wr_ack_q) begin
        if (wr_cnt >= aes_package::WORDS_PER_BLOCK) begin
          log_error("more writes than words in a block");
        end else begin
          exp_addr = dst_base_i +
                     hwpe_ctrl_package::addr_t'(wr_cnt * hwpe_ctrl_package::WORD_BYTES);
          exp_word = exp_block_i[wr_cnt*aes_package::WORD_BITS +: aes_package::WORD_BITS];
          if (wr_addr_i !== exp_addr) begin
            log_error($sformatf("write %0d address %h, expected %h", wr_cnt, wr_addr_i,
                                exp_addr));
          end
          if (wr_data_i !== exp_word) begin
            log_error($sformatf("write %0d data %h, expected %h", wr_cnt, wr_data_i, exp_word));
          end
        end
        wr_cnt++;
      end
      if (done_i) begin
        if (rd_cnt != aes_package::WORDS_PER_BLOCK || wr_cnt != aes_package::WORDS_PER_BLOCK) begin
          log_error($sformatf("done after %0d reads and %0d writes", rd_cnt, wr_cnt));
        end
        if (wr_ack_i) begin
          log_error("done raised before the last write ack fell");
        end
        if (test_errors == 0) begin
          $display("test %0d: pass", test_idx_i);
        end else begin
          $display("test %0d: fail, %0d errors", test_idx_i, test_errors);
        end
        jobs_o++;
        rd_cnt      = 0;
        wr_cnt      = 0;
        test_errors = 0;
        busy        = 1'b0;
      end
      rd_ack_q = rd_ack_i;
      wr_ack_q = wr_ack_i;
    end
  end

endmodule

`default_nettype wire

//--- tests/aes_hwpe_properties.sv
`timescale 1ns/100ps
`default_nettype none

module aes_hwpe_properties (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       rd_req_i,
  input  hwpe_ctrl_package::addr_t   rd_addr_i,
  input  logic                       rd_ack_i,
  input  logic                       wr_req_i,
  input  hwpe_ctrl_package::addr_t   wr_addr_i,
  input  aes_package::word_t         wr_data_i,
  input  logic                       wr_ack_i,
  input  logic                       done_i
);

  int rd_phase_fails = 0;
  int wr_phase_fails = 0;
  int rd_stable_fails = 0;
  int wr_stable_fails = 0;
  int done_fails = 0;
  int failures;

  assign failures = rd_phase_fails + wr_phase_fails + rd_stable_fails +
                    wr_stable_fails + done_fails;

  // While req and ack differ, req must hold its level
  rd_phase: assert property (@(posedge clk) disable iff (!reset_n)
    (rd_req_i ^ rd_ack_i) |=> $stable(rd_req_i))
    else begin
      $error("read req changed before ack followed");
      rd_phase_fails++;
    end

  wr_phase: assert property (@(posedge clk) disable iff (!reset_n)
    (wr_req_i ^ wr_ack_i) |=> $stable(wr_req_i))
    else begin
      $error("write req changed before ack followed");
      wr_phase_fails++;
    end

  rd_stable: assert property (@(posedge clk) disable iff (!reset_n)
    rd_req_i |=> !rd_req_i || $stable(rd_addr_i))
    else begin
      $error("read address moved during a request");
      rd_stable_fails++;
    end

  wr_stable: assert property (@(posedge clk) disable iff (!reset_n)
    wr_req_i |=> !wr_req_i || $stable({wr_addr_i, wr_data_i}))
    else begin
      $error("write address or data moved during a request");
      wr_stable_fails++;
    end

  done_once: assert property (@(posedge clk) disable iff (!reset_n)
    done_i |=> !done_i)
    else begin
      $error("done held longer than one cycle");
      done_fails++;
    end

endmodule

`default_nettype wire

//--- logic/aes_hwpe_top.sv
`timescale 1ns/100ps
`default_nettype none

module aes_hwpe_top (
  input  logic                       clk,
  input  logic                       reset_n,
  // Host
  input  logic                       start_i,
  input  hwpe_ctrl_package::addr_t   src_base_i,
  input  hwpe_ctrl_package::addr_t   dst_base_i,
  input  aes_package::key_t          key_i,
  output logic                       done_o,
  // Read port
  output logic                       rd_req_o,
  output hwpe_ctrl_package::addr_t   rd_addr_o,
  input  logic                       rd_ack_i,
  input  aes_package::word_t         rd_data_i,
  // Write port
  output logic                       wr_req_o,
  output hwpe_ctrl_package::addr_t   wr_addr_o,
  output aes_package::word_t         wr_data_o,
  input  logic                       wr_ack_i
);

  logic               src_start;
  logic               snk_start;
  logic               key_load;
  logic               src_ready;
  logic               snk_ready;
  logic               snk_last;
  // Source to engine
  logic               src_valid;
  aes_package::word_t src_word;
  logic               src_ready_in;
  // Engine to sink
  logic               eng_valid;
  aes_package::word_t eng_word;
  logic               eng_ready;

  aes_fsm aes_fsm_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_i     (start_i),
    .done_o      (done_o),
    .src_ready_i (src_ready),
    .snk_ready_i (snk_ready),
    .snk_last_i  (snk_last),
    .src_start_o (src_start),
    .snk_start_o (snk_start),
    .key_load_o  (key_load)
  );

  aes_stream_source aes_stream_source_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_i     (src_start),
    .base_i      (src_base_i),
    .ready_o     (src_ready),
    .rd_req_o    (rd_req_o),
    .rd_addr_o   (rd_addr_o),
    .rd_ack_i    (rd_ack_i),
    .rd_data_i   (rd_data_i),
    .out_valid_o (src_valid),
    .out_word_o  (src_word),
    .out_ready_i (src_ready_in)
  );

  aes_whitening_engine aes_whitening_engine_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .key_load_i  (key_load),
    .key_i       (key_i),
    .in_valid_i  (src_valid),
    .in_word_i   (src_word),
    .in_ready_o  (src_ready_in),
    .out_valid_o (eng_valid),
    .out_word_o  (eng_word),
    .out_ready_i (eng_ready)
  );

  aes_stream_sink aes_stream_sink_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .start_i    (snk_start),
    .base_i     (dst_base_i),
    .ready_o    (snk_ready),
    .last_o     (snk_last),
    .in_valid_i (eng_valid),
    .in_word_i  (eng_word),
    .in_ready_o (eng_ready),
    .wr_req_o   (wr_req_o),
    .wr_addr_o  (wr_addr_o),
    .wr_data_o  (wr_data_o),
    .wr_ack_i   (wr_ack_i)
  );

endmodule

`default_nettype wire

//--- logic/aes_whitening_engine.sv
`timescale 1ns/100ps
`default_nettype none

module aes_whitening_engine (
  input  logic                 clk,
  input  logic                 reset_n,
  // Key path
  input  logic                 key_load_i,
  input  aes_package::key_t    key_i,
  // Plaintext in
  input  logic                 in_valid_i,
  input  aes_package::word_t   in_word_i,
  output logic                 in_ready_o,
  // Whitened word out
  output logic                 out_valid_o,
  output aes_package::word_t   out_word_o,
  input  logic                 out_ready_i
);

  aes_package::key_t                            key_q;
  aes_package::word_idx_t                       idx_q;
  aes_package::word_t                           word_q;
  logic                                         full_q;
  logic [$clog2(aes_package::KEY_WORDS)-1:0]    key_sel;
  aes_package::word_t                           key_word;
  logic                                         accept;

  // Index mod KEY_WORDS picks the key word
  assign key_sel  = idx_q[$clog2(aes_package::KEY_WORDS)-1:0];
  assign key_word = key_q[key_sel*aes_package::WORD_BITS +: aes_package::WORD_BITS];

  // One-deep register, refuses input while holding a word
  assign in_ready_o = !full_q;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin : key_seq
    if (key_load_i) begin
      key_q <= key_i;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin : ctrl_seq
    if (!reset_n) begin
      idx_q  <= '0;
      full_q <= 1'b0;
    end else begin
      if (key_load_i) begin
        idx_q <= '0;
      end else if (accept) begin
        idx_q <= idx_q + 1'b1;
      end
      if (accept) begin
        full_q <= 1'b1;
      end else if (out_ready_i) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin : data_seq
    if (accept) begin
      word_q <= in_word_i ^ key_word;
    end
  end

  assign out_valid_o = full_q;
  assign out_word_o  = word_q;

endmodule

`default_nettype wire

//--- logic/aes_stream_sink.sv
`timescale 1ns/100ps
`default_nettype none

module aes_stream_sink (
  input  logic                       clk,
  input  logic                       reset_n,
  // Control
  input  logic                       start_i,
  input  hwpe_ctrl_package::addr_t   base_i,
  output logic                       ready_o,
  output logic                       last_o,
  // Stream in
  input  logic                       in_valid_i,
  input  aes_package::word_t         in_word_i,
  output logic                       in_ready_o,
  // Four-phase write port
  output logic                       wr_req_o,
  output hwpe_ctrl_package::addr_t   wr_addr_o,
  output aes_package::word_t         wr_data_o,
  input  logic                       wr_ack_i
);

  hwpe_ctrl_package::stream_state_t state_q;
  hwpe_ctrl_package::addr_t         addr_q;
  aes_package::word_idx_t           idx_q;
  aes_package::word_t               data_q;
  logic                             last_word;
  logic                             write_done;

  assign last_word  = (idx_q == aes_package::word_idx_t'(aes_package::WORDS_PER_BLOCK - 1));
  // A write completes when ack falls
  assign write_done = (state_q == hwpe_ctrl_package::STR_RELEASE) && !wr_ack_i;

  always_ff @(posedge clk or negedge reset_n) begin : ctrl_seq
    if (!reset_n) begin
      state_q <= hwpe_ctrl_package::STR_IDLE;
      addr_q  <= '0;
      idx_q   <= '0;
    end else begin
      case (state_q)
        hwpe_ctrl_package::STR_IDLE: begin
          if (start_i) begin
            addr_q  <= base_i;
            idx_q   <= '0;
            state_q <= hwpe_ctrl_package::STR_HANDOFF;
          end
        end
        // Waiting for the next word from the engine
        hwpe_ctrl_package::STR_HANDOFF: begin
          if (in_valid_i) begin
            state_q <= hwpe_ctrl_package::STR_REQ;
          end
        end
        hwpe_ctrl_package::STR_REQ: begin
          if (wr_ack_i) begin
            state_q <= hwpe_ctrl_package::STR_RELEASE;
          end
        end
        hwpe_ctrl_package::STR_RELEASE: begin
          if (write_done) begin
            if (last_word) begin
              state_q <= hwpe_ctrl_package::STR_IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              addr_q  <= addr_q + hwpe_ctrl_package::addr_t'(hwpe_ctrl_package::WORD_BYTES);
              state_q <= hwpe_ctrl_package::STR_HANDOFF;
            end
          end
        end
        default: state_q <= hwpe_ctrl_package::STR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin : data_seq
    if (in_valid_i && in_ready_o) begin
      data_q <= in_word_i;
    end
  end

  assign ready_o    = (state_q == hwpe_ctrl_package::STR_IDLE);
  assign in_ready_o = (state_q == hwpe_ctrl_package::STR_HANDOFF);
  assign wr_req_o   = (state_q == hwpe_ctrl_package::STR_REQ);
  assign wr_addr_o  = addr_q;
  assign wr_data_o  = data_q;
  assign last_o     = write_done && last_word;

endmodule

`default_nettype wire

//--- logic/aes_stream_source.sv
`timescale 1ns/100ps
`default_nettype none

module aes_stream_source (
  input  logic                       clk,
  input  logic                       reset_n,
  // Control
  input  logic                       start_i,
  input  hwpe_ctrl_package::addr_t   base_i,
  output logic                       ready_o,
  // Four-phase read port
  output logic                       rd_req_o,
  output hwpe_ctrl_package::addr_t   rd_addr_o,
  input  logic                       rd_ack_i,
  input  aes_package::word_t         rd_data_i,
  // Stream out
  output logic                       out_valid_o,
  output aes_package::word_t         out_word_o,
  input  logic                       out_ready_i
);

  hwpe_ctrl_package::stream_state_t state_q;
  hwpe_ctrl_package::addr_t         addr_q;
  aes_package::word_idx_t           idx_q;
  aes_package::word_t               data_q;
  logic                             last_word;

  assign last_word = (idx_q == aes_package::word_idx_t'(aes_package::WORDS_PER_BLOCK - 1));

  always_ff @(posedge clk or negedge reset_n) begin : ctrl_seq
    if (!reset_n) begin
      state_q <= hwpe_ctrl_package::STR_IDLE;
      addr_q  <= '0;
      idx_q   <= '0;
    end else begin
      case (state_q)
        hwpe_ctrl_package::STR_IDLE: begin
          if (start_i) begin
            addr_q  <= base_i;
            idx_q   <= '0;
            state_q <= hwpe_ctrl_package::STR_REQ;
          end
        end
        hwpe_ctrl_package::STR_REQ: begin
          if (rd_ack_i) begin
            state_q <= hwpe_ctrl_package::STR_RELEASE;
          end
        end
        // Memory must drop ack before the word moves on
        hwpe_ctrl_package::STR_RELEASE: begin
          if (!rd_ack_i) begin
            state_q <= hwpe_ctrl_package::STR_HANDOFF;
          end
        end
        hwpe_ctrl_package::STR_HANDOFF: begin
          if (out_ready_i) begin
            if (last_word) begin
              state_q <= hwpe_ctrl_package::STR_IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              addr_q  <= addr_q + hwpe_ctrl_package::addr_t'(hwpe_ctrl_package::WORD_BYTES);
              state_q <= hwpe_ctrl_package::STR_REQ;
            end
          end
        end
        default: state_q <= hwpe_ctrl_package::STR_IDLE;
      endcase
    end
  end

  // Read data captured at the rise of ack
  always_ff @(posedge clk) begin : data_seq
    if (state_q == hwpe_ctrl_package::STR_REQ && rd_ack_i) begin
      data_q <= rd_data_i;
    end
  end

  assign ready_o     = (state_q == hwpe_ctrl_package::STR_IDLE);
  assign rd_req_o    = (state_q == hwpe_ctrl_package::STR_REQ);
  assign rd_addr_o   = addr_q;
  assign out_valid_o = (state_q == hwpe_ctrl_package::STR_HANDOFF);
  assign out_word_o  = data_q;

endmodule

`default_nettype wire

//--- logic/aes_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module aes_fsm (
  input  logic clk,
  input  logic reset_n,
  // Host side
  input  logic start_i,
  output logic done_o,
  // Streamer handshake
  input  logic src_ready_i,
  input  logic snk_ready_i,
  input  logic snk_last_i,
  output logic src_start_o,
  output logic snk_start_o,
  // Engine key capture
  output logic key_load_o
);

  hwpe_ctrl_package::aes_state_t current_state;
  hwpe_ctrl_package::aes_state_t next_state;
  logic launch;

  // Both streamers idle while waiting to launch
  assign launch = (current_state == hwpe_ctrl_package::AES_STARTING) &&
                  src_ready_i && snk_ready_i;

  always_ff @(posedge clk or negedge reset_n) begin : fsm_seq
    if (!reset_n) begin
      current_state <= hwpe_ctrl_package::AES_IDLE;
    end else begin
      current_state <= next_state;
    end
  end

  always_comb begin : fsm_next
    next_state = current_state;
    case (current_state)
      hwpe_ctrl_package::AES_IDLE: begin
        if (start_i) begin
          next_state = hwpe_ctrl_package::AES_STARTING;
        end
      end
      hwpe_ctrl_package::AES_STARTING: begin
        if (launch) begin
          next_state = hwpe_ctrl_package::AES_WORKING;
        end
      end
      // Job ends on the sink's final write, not a cycle count
      hwpe_ctrl_package::AES_WORKING: begin
        if (snk_last_i) begin
          next_state = hwpe_ctrl_package::AES_FINISHED;
        end
      end
      hwpe_ctrl_package::AES_FINISHED: begin
        next_state = hwpe_ctrl_package::AES_IDLE;
      end
      default: begin
        next_state = hwpe_ctrl_package::AES_IDLE;
      end
    endcase
  end

  // Launch pulses last one cycle since the state leaves STARTING
  always_comb begin : fsm_out
    src_start_o = launch;
    snk_start_o = launch;
    key_load_o  = launch;
    done_o      = (current_state == hwpe_ctrl_package::AES_FINISHED);
  end

endmodule

`default_nettype wire

//--- logic/hwpe_ctrl_package.sv
`default_nettype none

// Control-side types: addressing and state machines
package hwpe_ctrl_package;

  localparam int ADDR_BITS = 32;

  // Byte step between consecutive words
  localparam int WORD_BYTES = 4;

  typedef logic [ADDR_BITS-1:0] addr_t;

  // Job controller
  typedef enum logic [1:0] {
    AES_IDLE,
    AES_STARTING,
    AES_WORKING,
    AES_FINISHED
  } aes_state_t;

  // Shared by source and sink streamers
  typedef enum logic [1:0] {
    STR_IDLE,
    STR_REQ,
    STR_RELEASE,
    STR_HANDOFF
  } stream_state_t;

endpackage

`default_nettype wire

//--- logic/aes_package.sv
`default_nettype none

// Data-path sizes and types of the whitening accelerator
package aes_package;

  // One memory and data word
  localparam int WORD_BITS = 32;

  // Words moved per job
  localparam int WORDS_PER_BLOCK = 8;

  // 128-bit key seen as 32-bit words
  localparam int KEY_WORDS = 4;

  typedef logic [WORD_BITS-1:0] word_t;

  // Key word k sits in bits 32k+31 down to 32k
  typedef logic [KEY_WORDS*WORD_BITS-1:0] key_t;

  // Position of a word inside its block
  typedef logic [2:0] word_idx_t;

endpackage

`default_nettype wire
